/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    ////////////////////
    // Address and data
    ////////////////////

    typedef logic [31:0] addr_t;    // Instruction or data address
    typedef logic [31:0] word_t;    // Machine word

    // Instructions are word aligned, so the low pc bits carry nothing
    localparam int INSN_ALIGN = 2;

endpackage

`default_nettype wire

/* bp_pkg.sv */
`default_nettype none

package bp_pkg;

    ////////////////////
    // Counters
    ////////////////////

    typedef logic [1:0] counter_t;  // 0-1 not taken, 2-3 taken

    localparam counter_t CNT_MIN = 2'b00;
    localparam counter_t CNT_MAX = 2'b11;

    // One training step of a saturating counter
    function automatic counter_t counter_step(counter_t cnt, logic up);
        counter_t next;
        next = cnt;
        if (up && cnt != CNT_MAX)
            next = cnt + 2'd1;
        else if (!up && cnt != CNT_MIN)
            next = cnt - 2'd1;
        return next;
    endfunction

    ////////////////////
    // Interface structs
    ////////////////////

    typedef struct packed {
        logic           valid;  // One update per edge while high
        cpu_pkg::addr_t pc;
        logic           taken;  // Resolved outcome
    } br_info_t;

    typedef struct packed {
        logic taken;            // Final direction
        logic use_global;       // Chooser picked gshare
        logic local_taken;
        logic global_taken;
    } bp_pred_t;

endpackage

`default_nettype wire

/* bp_local_history.sv */
`timescale 1ns/10ps
`default_nettype none

module bp_local_history #(
    parameter int WIDTH_PC   = 5,
    parameter int WIDTH_HIST = 6
) (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::addr_t    pc,
    input  bp_pkg::br_info_t  brinfo,
    output logic              pred_taken,
    output logic              upd_taken
);

    localparam int WIDTH_IDX = WIDTH_HIST + WIDTH_PC;
    localparam int SIZE_PC   = 2 ** WIDTH_PC;
    localparam int SIZE_CNT  = 2 ** WIDTH_IDX;
    localparam int LSB       = cpu_pkg::INSN_ALIGN;

    typedef logic [WIDTH_PC-1:0]   pcx_t;
    typedef logic [WIDTH_HIST-1:0] hist_t;
    typedef logic [WIDTH_IDX-1:0]  cnt_idx_t;

    hist_t             history  [SIZE_PC];   // pcx -> local history
    bp_pkg::counter_t  counters [SIZE_CNT];  // {hist, pcx} -> counter

    pcx_t              q_pcx;
    pcx_t              u_pcx;
    cnt_idx_t          q_idx;
    cnt_idx_t          u_idx;
    bp_pkg::counter_t  q_cnt;
    bp_pkg::counter_t  u_cnt;

    ////////////////////
    // Lookup
    ////////////////////

    assign q_pcx = pc[LSB +: WIDTH_PC];
    assign u_pcx = brinfo.pc[LSB +: WIDTH_PC];

    assign q_idx = {history[q_pcx], q_pcx};
    assign u_idx = {history[u_pcx], u_pcx};

    assign q_cnt = counters[q_idx];
    assign u_cnt = counters[u_idx];   // Current state, before this edge

    assign pred_taken = q_cnt[1];
    assign upd_taken  = u_cnt[1];

    ////////////////////
    // Training
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < SIZE_CNT; i++) begin
                counters[i] <= '0;
            end
            for (int i = 0; i < SIZE_PC; i++) begin
                history[i] <= '0;
            end
        end else if (brinfo.valid) begin
            counters[u_idx] <= bp_pkg::counter_step(u_cnt, brinfo.taken);
            // Outcome enters at bit 0
            history[u_pcx] <= {history[u_pcx][WIDTH_HIST-2:0], brinfo.taken};
        end
    end

endmodule

`default_nettype wire

/* bp_gshare.sv */
`timescale 1ns/10ps
`default_nettype none

module bp_gshare #(
    parameter int WIDTH_GHIST = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::addr_t    pc,
    input  bp_pkg::br_info_t  brinfo,
    output logic              pred_taken,
    output logic              upd_taken
);

    localparam int SIZE_CNT = 2 ** WIDTH_GHIST;
    localparam int LSB      = cpu_pkg::INSN_ALIGN;

    typedef logic [WIDTH_GHIST-1:0] ghist_t;   // Also the table index width

    ghist_t            ghr;                    // Global outcome history
    bp_pkg::counter_t  counters [SIZE_CNT];

    ghist_t            q_idx;
    ghist_t            u_idx;
    bp_pkg::counter_t  q_cnt;
    bp_pkg::counter_t  u_cnt;

    ////////////////////
    // Lookup
    ////////////////////

    // Both sides hash with the same ghr value
    assign q_idx = pc[LSB +: WIDTH_GHIST] ^ ghr;
    assign u_idx = brinfo.pc[LSB +: WIDTH_GHIST] ^ ghr;

    assign q_cnt = counters[q_idx];
    assign u_cnt = counters[u_idx];

    assign pred_taken = q_cnt[1];
    assign upd_taken  = u_cnt[1];

    ////////////////////
    // Training
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < SIZE_CNT; i++) begin
                counters[i] <= '0;
            end
        end else if (brinfo.valid) begin
            counters[u_idx] <= bp_pkg::counter_step(u_cnt, brinfo.taken);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ghr <= '0;
        end else if (brinfo.valid) begin
            ghr <= {ghr[WIDTH_GHIST-2:0], brinfo.taken};   // Newest at bit 0
        end
    end

endmodule

`default_nettype wire

/* bp_chooser.sv */
`timescale 1ns/10ps
`default_nettype none

module bp_chooser #(
    parameter int WIDTH_PC = 5
) (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::addr_t    pc,
    input  bp_pkg::br_info_t  brinfo,
    input  logic              local_taken,   // Votes for the query pc
    input  logic              global_taken,
    input  logic              local_upd,     // Votes for the update pc
    input  logic              global_upd,
    output bp_pkg::bp_pred_t  pred
);

    localparam int SIZE_PC = 2 ** WIDTH_PC;
    localparam int LSB     = cpu_pkg::INSN_ALIGN;

    typedef logic [WIDTH_PC-1:0] pcx_t;

    bp_pkg::counter_t  choice [SIZE_PC];   // High half favors gshare

    pcx_t              q_pcx;
    pcx_t              u_pcx;
    bp_pkg::counter_t  q_cnt;
    bp_pkg::counter_t  u_cnt;
    logic              use_global;
    logic              disagree;
    logic              global_right;

    ////////////////////
    // Selection
    ////////////////////

    assign q_pcx = pc[LSB +: WIDTH_PC];
    assign q_cnt = choice[q_pcx];

    assign use_global = q_cnt[1];

    always_comb begin
        pred              = '0;
        pred.use_global   = use_global;
        pred.local_taken  = local_taken;
        pred.global_taken = global_taken;
        pred.taken        = use_global ? global_taken : local_taken;
    end

    ////////////////////
    // Training
    ////////////////////

    assign u_pcx = brinfo.pc[LSB +: WIDTH_PC];
    assign u_cnt = choice[u_pcx];

    // Only a disagreement says anything about which side is better
    assign disagree     = local_upd != global_upd;
    assign global_right = global_upd == brinfo.taken;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < SIZE_PC; i++) begin
                choice[i] <= '0;
            end
        end else if (brinfo.valid && disagree) begin
            choice[u_pcx] <= bp_pkg::counter_step(u_cnt, global_right);
        end
    end

endmodule

`default_nettype wire

/* bp_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module bp_unit #(
    parameter int WIDTH_PC    = 5,
    parameter int WIDTH_HIST  = 6,
    parameter int WIDTH_GHIST = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::addr_t    pc,       // Fetch query
    input  bp_pkg::br_info_t  brinfo,   // Resolved branch from execute
    output bp_pkg::bp_pred_t  pred
);

    logic local_taken;
    logic local_upd;
    logic global_taken;
    logic global_upd;

    ////////////////////
    // Components
    ////////////////////

    bp_local_history #(
        .WIDTH_PC   (WIDTH_PC),
        .WIDTH_HIST (WIDTH_HIST)
    ) u_local (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc         (pc),
        .brinfo     (brinfo),
        .pred_taken (local_taken),
        .upd_taken  (local_upd)
    );

    bp_gshare #(
        .WIDTH_GHIST (WIDTH_GHIST)
    ) u_gshare (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc         (pc),
        .brinfo     (brinfo),
        .pred_taken (global_taken),
        .upd_taken  (global_upd)
    );

    ////////////////////
    // Chooser
    ////////////////////

    bp_chooser #(
        .WIDTH_PC (WIDTH_PC)
    ) u_chooser (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc           (pc),
        .brinfo       (brinfo),
        .local_taken  (local_taken),
        .global_taken (global_taken),
        .local_upd    (local_upd),
        .global_upd   (global_upd),
        .pred         (pred)
    );

endmodule

`default_nettype wire

/* tb_bp_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_bp_unit;

    localparam int WIDTH_PC      = 5;
    localparam int WIDTH_HIST    = 6;
    localparam int WIDTH_GHIST   = 8;
    localparam int N_PC          = 2 ** WIDTH_PC;
    localparam int N_LCNT        = 2 ** (WIDTH_PC + WIDTH_HIST);
    localparam int N_GCNT        = 2 ** WIDTH_GHIST;
    localparam int POOL          = 8;
    localparam int RESET_TIMEOUT = 20;     // Cycles
    localparam int RANDOM_CYCLES = 3000;

    typedef logic [WIDTH_PC-1:0]            pcx_t;
    typedef logic [WIDTH_HIST-1:0]          hist_t;
    typedef logic [WIDTH_PC+WIDTH_HIST-1:0] lidx_t;
    typedef logic [WIDTH_GHIST-1:0]         ghist_t;

    logic              clk;
    logic              rst_n;
    cpu_pkg::addr_t    pc;
    bp_pkg::br_info_t  brinfo;
    bp_pkg::bp_pred_t  pred;

    // Reference model state
    hist_t             m_hist   [N_PC];
    bp_pkg::counter_t  m_lcnt   [N_LCNT];
    ghist_t            m_ghr;
    bp_pkg::counter_t  m_gcnt   [N_GCNT];
    bp_pkg::counter_t  m_choice [N_PC];

    cpu_pkg::addr_t    pool [POOL];        // Distinct pc index per entry
    logic [31:0]       lcg_state;

    bp_unit #(
        .WIDTH_PC    (WIDTH_PC),
        .WIDTH_HIST  (WIDTH_HIST),
        .WIDTH_GHIST (WIDTH_GHIST)
    ) i_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .pc     (pc),
        .brinfo (brinfo),
        .pred   (pred)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

    ////////////////////
    // Model
    ////////////////////

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic pcx_t pcx_of(cpu_pkg::addr_t a);
        return a[2 +: WIDTH_PC];           // Word aligned pc
    endfunction

    function automatic lidx_t local_index(cpu_pkg::addr_t a);
        pcx_t p;
        p = pcx_of(a);
        return {m_hist[p], p};
    endfunction

    function automatic ghist_t gshare_index(cpu_pkg::addr_t a);
        return a[2 +: WIDTH_GHIST] ^ m_ghr;
    endfunction

    function automatic bp_pkg::counter_t saturate_step(bp_pkg::counter_t c, logic up);
        if (up)
            return (c == 2'd3) ? c : c + 2'd1;
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    function automatic bp_pkg::bp_pred_t model_pred(cpu_pkg::addr_t a);
        bp_pkg::bp_pred_t p;
        p.local_taken  = m_lcnt[local_index(a)][1];
        p.global_taken = m_gcnt[gshare_index(a)][1];
        p.use_global   = m_choice[pcx_of(a)][1];
        p.taken        = p.use_global ? p.global_taken : p.local_taken;
        return p;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < N_PC; i++) begin
            m_hist[i]   = '0;
            m_choice[i] = '0;
        end
        for (int i = 0; i < N_LCNT; i++) begin
            m_lcnt[i] = '0;
        end
        for (int i = 0; i < N_GCNT; i++) begin
            m_gcnt[i] = '0;
        end
        m_ghr = '0;
    endtask

    task automatic model_update(bp_pkg::br_info_t br);
        pcx_t   p;
        lidx_t  li;
        ghist_t gi;
        logic   lu;
        logic   gu;
        p  = pcx_of(br.pc);
        li = local_index(br.pc);           // Indices from the old histories
        gi = gshare_index(br.pc);
        lu = m_lcnt[li][1];
        gu = m_gcnt[gi][1];
        if (lu != gu)
            m_choice[p] = saturate_step(m_choice[p], gu == br.taken);
        m_lcnt[li] = saturate_step(m_lcnt[li], br.taken);
        m_hist[p]  = {m_hist[p][WIDTH_HIST-2:0], br.taken};
        m_gcnt[gi] = saturate_step(m_gcnt[gi], br.taken);
        m_ghr      = {m_ghr[WIDTH_GHIST-2:0], br.taken};
    endtask

    ////////////////////
    // Checks
    ////////////////////

    task automatic fail_run(string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_pred(string what, bp_pkg::bp_pred_t act, bp_pkg::bp_pred_t exp);
        if (act !== exp)
            fail_run($sformatf("Mismatch at %0t ns: %s, pred %b expected %b %s",
                               $time, what, act, exp, "(taken use_global local global)"));
    endtask

    task automatic check_counter(string what, bp_pkg::counter_t act, bp_pkg::counter_t exp);
        if (act !== exp)
            fail_run($sformatf("Mismatch at %0t ns: %s, counter %0d expected %0d",
                               $time, what, act, exp));
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst_n !== 1'b1) begin
            if (n == RESET_TIMEOUT)
                fail_run("Timeout: reset was never released");
            else begin
                @(negedge clk);
                n++;
            end
        end
    endtask

    // Called at a falling edge, returns at the next one
    task automatic step(cpu_pkg::addr_t q_pc, logic u_valid, cpu_pkg::addr_t u_pc,
                        logic u_taken);
        bp_pkg::br_info_t br;
        br.valid = u_valid;
        br.pc    = u_pc;
        br.taken = u_taken;
        pc       = q_pc;
        brinfo   = br;
        #5;
        check_pred("query", pred, model_pred(q_pc));   // Pre-update state
        @(posedge clk);
        if (u_valid)
            model_update(br);
        @(negedge clk);
    endtask

    task automatic train(cpu_pkg::addr_t a, logic taken);
        step(a, 1'b1, a, taken);
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        bp_pkg::bp_pred_t expect_pred;
        logic [31:0]      r;
        cpu_pkg::addr_t   pa;
        cpu_pkg::addr_t   pb;
        cpu_pkg::addr_t   pcc;
        cpu_pkg::addr_t   pd;
        logic             c_taken;
        logic             outcome;
        lidx_t            li;
        ghist_t           gi;

        pc        = '0;
        brinfo    = '0;
        lcg_state = 32'h4f7a94ec;
        for (int i = 0; i < POOL; i++) begin
            pool[i] = 32'h0040_0000 + 32'h14 * i;
        end
        model_reset();
        wait_reset_release();

        for (int i = 0; i < POOL; i++) begin
            step(pool[i], 1'b0, '0, 1'b0);
            check_pred("reset state", pred, '0);
        end

        // Always taken, local history and ghr fill with ones
        pa = pool[0];
        repeat (22) train(pa, 1'b1);
        expect_pred              = '0;
        expect_pred.taken        = 1'b1;
        expect_pred.local_taken  = 1'b1;
        expect_pred.global_taken = 1'b1;
        check_pred("always taken", pred, expect_pred);
        li = {{WIDTH_HIST{1'b1}}, pcx_of(pa)};
        gi = pa[2 +: WIDTH_GHIST] ^ {WIDTH_GHIST{1'b1}};
        check_counter("local saturated", i_dut.u_local.counters[li], 2'd3);
        check_counter("gshare saturated", i_dut.u_gshare.counters[gi], 2'd3);
        train(pa, 1'b0);
        check_counter("local after one miss", i_dut.u_local.counters[li], 2'd2);
        check_counter("gshare after one miss", i_dut.u_gshare.counters[gi], 2'd2);

        // Period-3 pattern
        pb = pool[1];
        for (int k = 0; k < 69; k++) begin
            outcome = (k % 3) != 2;
            if (k >= 60)
                check_counter("local pattern", i_dut.u_local.counters[local_index(pb)],
                              outcome ? 2'd3 : 2'd0);
            train(pb, outcome);
        end

        // Second pc repeats the first one's outcome
        pcc = pool[2];
        pd  = pool[3];
        for (int k = 0; k < 300; k++) begin
            r       = next_random();
            c_taken = r[16];
            train(pcc, c_taken);
            train(pd, c_taken);
        end
        check_counter("choice copying pc", i_dut.u_chooser.choice[pcx_of(pd)],
                      m_choice[pcx_of(pd)]);
        check_counter("choice random pc", i_dut.u_chooser.choice[pcx_of(pcc)],
                      m_choice[pcx_of(pcc)]);
        check_counter("gshare copying pc", i_dut.u_gshare.counters[gshare_index(pd)],
                      m_gcnt[gshare_index(pd)]);

        // Update against the current prediction, same pc as the query
        for (int i = 0; i < POOL; i++) begin
            expect_pred = model_pred(pool[i]);
            step(pool[i], 1'b1, pool[i], !expect_pred.taken);
            check_pred("after same-cycle update", pred, model_pred(pool[i]));
        end

        for (int k = 0; k < RANDOM_CYCLES; k++) begin
            r = next_random();
            step(pool[r[29:27]], r[31:30] != 2'b00, pool[r[26:24]], r[21]);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
cpu_pkg.sv
bp_pkg.sv
bp_local_history.sv
bp_gshare.sv
bp_chooser.sv
bp_unit.sv
tb_bp_unit.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_bp_unit -f list.f -o tb_bp_unit

# The pipeline status is the status of tee, so a failing run still reaches the grep
./obj_dir/tb_bp_unit 2>&1 | tee sim.log

if grep -qx "TB PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
